//--- include/mem_stage_macros.svh
`ifndef MEM_STAGE_MACROS_SVH
`define MEM_STAGE_MACROS_SVH

// Width of one data word in bits.
`define MEM_NB_DATA 32

// Byte address width for 128 bytes in total.
`define MEM_NB_ADDR 7

// Number of 32-bit words in the data memory.
`define MEM_NUM_WORDS 32

// Lowest words that ignore stores.
`define MEM_PROTECTED_WORDS 1

`endif

//--- hw/mem_stage_pkg.sv
`include "mem_stage_macros.svh"

package mem_stage_pkg;

    // Full data word.
    typedef logic [`MEM_NB_DATA-1:0] data_t;

    // Byte address into the data memory.
    typedef logic [`MEM_NB_ADDR-1:0] byte_addr_t;

    // Word index, the byte address without its two lane bits.
    typedef logic [`MEM_NB_ADDR-3:0] word_addr_t;

    // One enable per byte lane.
    typedef logic [3:0] byte_en_t;

    // Load and store operations of the stage.
    typedef enum logic [2:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        SB,
        SH,
        SW
    } mem_op_e;

    // States of the debug dump sequencer.
    typedef enum logic [1:0] {
        DUMP_IDLE,
        DUMP_RUN,
        DUMP_DONE
    } dump_state_e;

    // One request as it enters the stage.
    typedef struct packed {
        mem_op_e    op;
        byte_addr_t addr;
        data_t      wdata;
    } mem_req_t;

endpackage

//--- hw/store_aligner.sv
`timescale 1ns/1ps

`include "mem_stage_macros.svh"

module store_aligner import mem_stage_pkg::*; (
    input  mem_req_t   i_req,
    output word_addr_t o_word_addr,
    output byte_en_t   o_byte_en,
    output data_t      o_wdata
);

    logic [1:0] addr_low;

    assign addr_low    = i_req.addr[1:0];
    assign o_word_addr = i_req.addr[`MEM_NB_ADDR-1:2];

    // Lane selection and data replication by access size.
    always_comb begin
        case (i_req.op)
            LB, LBU, SB: begin
                o_byte_en = byte_en_t'(4'b0001 << addr_low);
                o_wdata   = {4{i_req.wdata[7:0]}};
            end
            LH, LHU, SH: begin
                o_byte_en = addr_low[1] ? 4'b1100 : 4'b0011;
                o_wdata   = {2{i_req.wdata[15:0]}};
            end
            default: begin
                o_byte_en = 4'b1111;
                o_wdata   = i_req.wdata;
            end
        endcase
    end

    // The memory and the formatter rely on these lane patterns only.
    always_comb begin
        a_lane_pattern: assert final (o_byte_en inside {4'b0001, 4'b0010, 4'b0100,
                                                        4'b1000, 4'b0011, 4'b1100,
                                                        4'b1111})
            else $error("store_aligner: illegal lane pattern %b", o_byte_en);
    end

endmodule

//--- hw/data_memory.sv
`timescale 1ns/1ps

`include "mem_stage_macros.svh"

module data_memory import mem_stage_pkg::*; (
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_write_en,
    input  logic       i_read_en,
    input  byte_en_t   i_byte_en,
    input  word_addr_t i_word_addr,
    input  data_t      i_wdata,
    input  word_addr_t i_debug_addr,
    output data_t      o_rdata,
    output data_t      o_debug_data
);

    localparam word_addr_t FIRST_WRITABLE = word_addr_t'(`MEM_PROTECTED_WORDS);

    // Each word holds four byte lanes with lane 0 at the lowest byte address.
    logic [3:0][7:0] mem_q [`MEM_NUM_WORDS];

    data_t rdata_q;
    data_t debug_q;
    logic  write_ok;

    // Words below the protected boundary never take a store.
    assign write_ok = i_write_en && (i_word_addr >= FIRST_WRITABLE);

    // Lane writes on the rising edge.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            for (int w = 0; w < `MEM_NUM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (write_ok) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (i_byte_en[lane]) begin
                    mem_q[i_word_addr][lane] <= i_wdata[lane*8 +: 8];
                end
            end
        end
    end

    // Reads are taken on the falling edge so data is ready at the next rising edge.
    // Disabled lanes read as zero.
    always_ff @(negedge i_clock) begin
        if (i_read_en) begin
            for (int lane = 0; lane < 4; lane++) begin
                rdata_q[lane*8 +: 8] <= i_byte_en[lane] ? mem_q[i_word_addr][lane] : 8'h00;
            end
        end
        debug_q <= mem_q[i_debug_addr];
    end

    assign o_rdata      = rdata_q;
    assign o_debug_data = debug_q;

    // A store strobe from the control must come with lanes from the aligner.
    a_write_has_lanes: assert property (@(posedge i_clock) disable iff (i_reset)
        i_write_en |-> (i_byte_en != '0))
        else $error("data_memory: write strobe without byte enables");

endmodule

//--- hw/load_formatter.sv
`timescale 1ns/1ps

module load_formatter import mem_stage_pkg::*; (
    input  mem_op_e    i_op,
    input  logic [1:0] i_addr_low,
    input  data_t      i_rdata,
    output data_t      o_load_data
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    // Move the addressed lane or lane pair down to bit 0.
    assign lane_byte = i_rdata[{i_addr_low, 3'b000} +: 8];
    assign lane_half = i_addr_low[1] ? i_rdata[31:16] : i_rdata[15:0];

    always_comb begin
        case (i_op)
            LB:      o_load_data = data_t'($signed(lane_byte));
            LBU:     o_load_data = data_t'(lane_byte);
            LH:      o_load_data = data_t'($signed(lane_half));
            LHU:     o_load_data = data_t'(lane_half);
            LW:      o_load_data = i_rdata;
            // Stores return nothing.
            default: o_load_data = '0;
        endcase
    end

endmodule

//--- hw/mem_stage_control.sv
`timescale 1ns/1ps

`include "mem_stage_macros.svh"

module mem_stage_control import mem_stage_pkg::*; (
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_req_valid,
    input  mem_op_e    i_op,
    input  logic [1:0] i_addr_low,
    input  logic       i_dump_start,
    output logic       o_write_en,
    output logic       o_read_en,
    output logic       o_load_valid,
    output logic       o_fault,
    output word_addr_t o_dump_addr,
    output logic       o_dump_valid,
    output logic       o_dump_done
);

    localparam word_addr_t LAST_WORD = word_addr_t'(`MEM_NUM_WORDS - 1);

    logic        is_store;
    logic        is_half;
    logic        is_word;
    logic        misaligned;
    dump_state_e state_q;
    word_addr_t  count_q;

    // Operation decode.
    always_comb begin
        is_store = 1'b0;
        is_half  = 1'b0;
        is_word  = 1'b0;
        case (i_op)
            SB: is_store = 1'b1;
            SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            SW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            LH, LHU: is_half = 1'b1;
            LW:      is_word = 1'b1;
            default: ;
        endcase
    end

    assign misaligned = (is_half && i_addr_low[0]) || (is_word && (i_addr_low != 2'b00));

    // A misaligned request only faults and never touches the memory.
    assign o_fault      = i_req_valid && misaligned;
    assign o_write_en   = i_req_valid && !misaligned && is_store;
    assign o_read_en    = i_req_valid && !misaligned && !is_store;
    assign o_load_valid = o_read_en;

    // Dump sequencer that presents one word index per cycle in DUMP_RUN.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state_q <= DUMP_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                DUMP_IDLE: begin
                    if (i_dump_start) begin
                        state_q <= DUMP_RUN;
                        count_q <= '0;
                    end
                end
                DUMP_RUN: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == LAST_WORD) begin
                        state_q <= DUMP_DONE;
                    end
                end
                DUMP_DONE: state_q <= DUMP_IDLE;
                default:   state_q <= DUMP_IDLE;
            endcase
        end
    end

    assign o_dump_addr  = count_q;
    assign o_dump_valid = (state_q == DUMP_RUN);
    assign o_dump_done  = (state_q == DUMP_DONE);

    a_strobes_exclusive: assert property (@(posedge i_clock) disable iff (i_reset)
        !(o_write_en && o_read_en))
        else $error("mem_stage_control: write and read strobes together");

    a_dump_valid_in_run: assert property (@(posedge i_clock) disable iff (i_reset)
        o_dump_valid |-> (state_q == DUMP_RUN))
        else $error("mem_stage_control: dump valid outside DUMP_RUN");

endmodule

//--- hw/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top import mem_stage_pkg::*; (
    input  logic       i_clock,
    input  logic       i_reset,
    input  logic       i_req_valid,
    input  mem_req_t   i_req,
    input  logic       i_dump_start,
    output logic       o_load_valid,
    output data_t      o_load_data,
    output logic       o_fault,
    output logic       o_dump_valid,
    output word_addr_t o_dump_addr,
    output data_t      o_dump_data,
    output logic       o_dump_done
);

    word_addr_t word_addr;
    byte_en_t   byte_en;
    data_t      store_data;
    data_t      read_data;
    logic       write_en;
    logic       read_en;

    mem_stage_control u_control (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_req_valid  (i_req_valid),
        .i_op         (i_req.op),
        .i_addr_low   (i_req.addr[1:0]),
        .i_dump_start (i_dump_start),
        .o_write_en   (write_en),
        .o_read_en    (read_en),
        .o_load_valid (o_load_valid),
        .o_fault      (o_fault),
        .o_dump_addr  (o_dump_addr),
        .o_dump_valid (o_dump_valid),
        .o_dump_done  (o_dump_done)
    );

    // Lane enables from the aligner also select the read lanes of a load.
    store_aligner u_aligner (
        .i_req       (i_req),
        .o_word_addr (word_addr),
        .o_byte_en   (byte_en),
        .o_wdata     (store_data)
    );

    data_memory u_memory (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_write_en   (write_en),
        .i_read_en    (read_en),
        .i_byte_en    (byte_en),
        .i_word_addr  (word_addr),
        .i_wdata      (store_data),
        .i_debug_addr (o_dump_addr),
        .o_rdata      (read_data),
        .o_debug_data (o_dump_data)
    );

    load_formatter u_formatter (
        .i_op        (i_req.op),
        .i_addr_low  (i_req.addr[1:0]),
        .i_rdata     (read_data),
        .o_load_data (o_load_data)
    );

endmodule

//--- bench/mem_stage_tb.sv
`timescale 1ns/1ps

`include "mem_stage_macros.svh"

module mem_stage_tb import mem_stage_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 600;

    logic       i_clock;
    logic       i_reset;
    logic       i_req_valid;
    mem_req_t   i_req;
    logic       i_dump_start;
    logic       o_load_valid;
    data_t      o_load_data;
    logic       o_fault;
    logic       o_dump_valid;
    word_addr_t o_dump_addr;
    data_t      o_dump_data;
    logic       o_dump_done;

    // Reference byte array with lane 0 of each word at the lowest address.
    logic [7:0] model [4*`MEM_NUM_WORDS];

    byte_addr_t  req_addr;
    byte_addr_t  half_base;
    byte_addr_t  word_base;
    byte_addr_t  dump_base;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    data_t       ld_word;
    data_t       exp_load;
    data_t       exp_dump;
    logic        req_is_store;
    logic        req_misaligned;
    int          dump_count;
    int          cycle_count;

    mem_stage_top dut (.*);

    initial begin
        i_clock = 1'b0;
        forever #4 i_clock = ~i_clock;
    end

    assign req_addr  = i_req.addr;
    assign half_base = {req_addr[`MEM_NB_ADDR-1:1], 1'b0};
    assign word_base = {req_addr[`MEM_NB_ADDR-1:2], 2'b00};
    assign dump_base = byte_addr_t'(4 * dump_count);
    assign ld_byte   = model[req_addr];
    assign ld_half   = {model[half_base + 1], model[half_base]};
    assign ld_word   = {model[word_base + 3], model[word_base + 2],
                        model[word_base + 1], model[word_base]};
    assign exp_dump  = {model[dump_base + 3], model[dump_base + 2],
                        model[dump_base + 1], model[dump_base]};

    assign req_is_store   = i_req.op inside {SB, SH, SW};
    assign req_misaligned = ((i_req.op inside {LH, LHU, SH}) && req_addr[0])
                         || ((i_req.op inside {LW, SW}) && (req_addr[1:0] != 2'b00));

    always_comb begin
        case (i_req.op)
            LB:      exp_load = {{24{ld_byte[7]}}, ld_byte};
            LBU:     exp_load = {24'h0, ld_byte};
            LH:      exp_load = {{16{ld_half[15]}}, ld_half};
            LHU:     exp_load = {16'h0, ld_half};
            default: exp_load = ld_word;
        endcase
    end

    // Model update at the edge that ends an aligned store. Word 0 keeps its value.
    always @(posedge i_clock) begin
        if (i_reset) begin
            for (int i = 0; i < 4*`MEM_NUM_WORDS; i++) begin
                model[i] <= 8'h00;
            end
        end else if (i_req_valid && req_is_store && !req_misaligned
                     && (req_addr[`MEM_NB_ADDR-1:2] >= `MEM_PROTECTED_WORDS)) begin
            case (i_req.op)
                SB: model[req_addr] <= i_req.wdata[7:0];
                SH: begin
                    model[half_base]     <= i_req.wdata[7:0];
                    model[half_base + 1] <= i_req.wdata[15:8];
                end
                default: begin
                    for (int lane = 0; lane < 4; lane++) begin
                        model[word_base + lane] <= i_req.wdata[lane*8 +: 8];
                    end
                end
            endcase
        end
    end

    // Number of dump words seen so far in the current dump.
    always @(posedge i_clock) begin
        if (i_reset || o_dump_done) begin
            dump_count <= 0;
        end else if (o_dump_valid) begin
            dump_count <= dump_count + 1;
        end
    end

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopping at the first error");
    endtask

    a_fault: assert property (@(posedge i_clock) disable iff (i_reset)
        o_fault == (i_req_valid && req_misaligned))
        else report_error("fault pulse does not match the alignment rule");

    a_load_valid: assert property (@(posedge i_clock) disable iff (i_reset)
        o_load_valid == (i_req_valid && !req_is_store && !req_misaligned))
        else report_error("load valid does not match the request");

    a_load_data: assert property (@(posedge i_clock) disable iff (i_reset)
        (i_req_valid && !req_is_store && !req_misaligned) |-> (o_load_data == exp_load))
        else report_error($sformatf("load data %h, expected %h",
                                    $sampled(o_load_data), $sampled(exp_load)));

    a_dump_addr: assert property (@(posedge i_clock) disable iff (i_reset)
        o_dump_valid |-> (o_dump_addr == dump_count))
        else report_error("dump address out of sequence");

    a_dump_data: assert property (@(posedge i_clock) disable iff (i_reset)
        o_dump_valid |-> (o_dump_data == exp_dump))
        else report_error($sformatf("dump data %h, expected %h",
                                    $sampled(o_dump_data), $sampled(exp_dump)));

    a_dump_length: assert property (@(posedge i_clock) disable iff (i_reset)
        o_dump_done |-> (dump_count == `MEM_NUM_WORDS))
        else report_error("dump done after the wrong number of words");

    a_dump_done_once: assert property (@(posedge i_clock) disable iff (i_reset)
        o_dump_done |=> (!o_dump_done && !o_dump_valid))
        else report_error("dump done not a single pulse");

    a_dump_begin: assert property (@(posedge i_clock) disable iff (i_reset)
        $rose(o_dump_valid) |-> $past(i_dump_start))
        else report_error("dump started without a start pulse");

    a_quiet_after_reset: assert property (@(posedge i_clock)
        $fell(i_reset) |-> !(o_load_valid || o_fault || o_dump_valid || o_dump_done))
        else report_error("output strobe high right after reset");

    task automatic drive_cycle(input logic valid, input mem_op_e op, input byte_addr_t addr,
                               input data_t wdata, input logic start);
        @(posedge i_clock);
        #1;
        i_req_valid  = valid;
        i_req.op     = op;
        i_req.addr   = addr;
        i_req.wdata  = wdata;
        i_dump_start = start;
    endtask

    task automatic idle_cycle();
        drive_cycle(1'b0, LB, '0, '0, 1'b0);
    endtask

    task automatic apply_reset();
        @(posedge i_clock);
        #1;
        i_reset      = 1'b1;
        i_req_valid  = 1'b0;
        i_dump_start = 1'b0;
        repeat (3) @(posedge i_clock);
        #1;
        i_reset = 1'b0;
    endtask

    function automatic byte_addr_t aligned_addr(input mem_op_e op);
        byte_addr_t addr;
        addr = byte_addr_t'($urandom);
        if (op inside {LH, LHU, SH}) addr[0] = 1'b0;
        if (op inside {LW, SW}) addr[1:0] = 2'b00;
        return addr;
    endfunction

    task automatic random_store(input logic start);
        mem_op_e op;
        op = ($urandom % 3 == 0) ? SB : (($urandom % 2 == 0) ? SH : SW);
        drive_cycle(1'b1, op, aligned_addr(op), data_t'($urandom), start);
    endtask

    // Every load type around one byte address.
    task automatic load_all_types(input byte_addr_t addr);
        drive_cycle(1'b1, LB, addr, '0, 1'b0);
        drive_cycle(1'b1, LBU, addr, '0, 1'b0);
        drive_cycle(1'b1, LH, {addr[`MEM_NB_ADDR-1:1], 1'b0}, '0, 1'b0);
        drive_cycle(1'b1, LHU, {addr[`MEM_NB_ADDR-1:1], 1'b0}, '0, 1'b0);
        drive_cycle(1'b1, LW, {addr[`MEM_NB_ADDR-1:2], 2'b00}, '0, 1'b0);
    endtask

    task automatic run_dump(input int second_start_at);
        drive_cycle(1'b0, LB, '0, '0, 1'b1);
        for (int i = 0; i < 20; i++) begin
            random_store(i == second_start_at);
        end
        idle_cycle();
        do @(negedge i_clock); while (!o_dump_done);
    endtask

    initial begin
        byte_addr_t addr;
        byte_addr_t base;
        i_reset      = 1'b1;
        i_req_valid  = 1'b0;
        i_req        = '0;
        i_dump_start = 1'b0;
        cycle_count  = 0;
        void'($urandom(32'hcc1a));
        apply_reset();
        idle_cycle();

        // Word store then word load of the same word.
        for (int i = 0; i < 8; i++) begin
            addr = aligned_addr(SW);
            drive_cycle(1'b1, SW, addr, data_t'($urandom), 1'b0);
            drive_cycle(1'b1, LW, addr, '0, 1'b0);
        end

        // Byte and half stores, then loads of every type.
        for (int i = 0; i < 16; i++) begin
            addr = aligned_addr(i % 2 == 0 ? SB : SH);
            drive_cycle(1'b1, (i % 2 == 0) ? SB : SH, addr, data_t'($urandom), 1'b0);
            load_all_types(addr);
        end

        // Misaligned requests fault and leave the word as it was.
        for (int i = 0; i < 4; i++) begin
            base = aligned_addr(LW);
            drive_cycle(1'b1, LH, base | 7'd1, '0, 1'b0);
            drive_cycle(1'b1, SH, base | 7'd3, data_t'($urandom), 1'b0);
            drive_cycle(1'b1, LW, base | byte_addr_t'(1 + $urandom % 3), '0, 1'b0);
            drive_cycle(1'b1, SW, base | byte_addr_t'(1 + $urandom % 3), data_t'($urandom), 1'b0);
            drive_cycle(1'b1, LW, base, '0, 1'b0);
        end

        // Word 0 takes no store.
        drive_cycle(1'b1, SW, 7'd0, data_t'($urandom), 1'b0);
        drive_cycle(1'b1, SB, 7'd1, data_t'($urandom), 1'b0);
        drive_cycle(1'b1, SH, 7'd2, data_t'($urandom), 1'b0);
        load_all_types(7'd0);
        load_all_types(7'd3);

        // Dump with stores running alongside and a second start mid-run.
        for (int i = 0; i < 12; i++) begin
            random_store(1'b0);
        end
        run_dump(6);

        // Second reset in the middle of a dump, then a dump of the cleared memory.
        drive_cycle(1'b0, LB, '0, '0, 1'b1);
        repeat (3) idle_cycle();
        apply_reset();
        idle_cycle();
        drive_cycle(1'b0, LB, '0, '0, 1'b1);
        idle_cycle();
        do @(negedge i_clock); while (!o_dump_done);
        repeat (2) idle_cycle();

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
hw/mem_stage_pkg.sv
hw/store_aligner.sv
hw/data_memory.sv
hw/load_formatter.sv
hw/mem_stage_control.sv
hw/mem_stage_top.sv
bench/mem_stage_tb.sv

//--- Bender.yml
package:
  name: mem_stage

export_include_dirs:
  - include

sources:
  - files:
      - hw/mem_stage_pkg.sv
      - hw/store_aligner.sv
      - hw/data_memory.sv
      - hw/load_formatter.sv
      - hw/mem_stage_control.sv
      - hw/mem_stage_top.sv
  - target: test
    files:
      - bench/mem_stage_tb.sv
